//--- Makefile
VERILATOR = verilator
VFLAGS = --timing --assert
TOP = decodeHazardTb
FILELIST = compile.f
OBJDIR = obj_dir
LOG = sim.log
PASS_MSG = All tests passed
FAIL_MSG = Some tests failed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# the log decides the result, so a crashed run without a verdict also fails.
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation gave no verdict"; exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- compile.f
verilog/hazardPkg.sv
verilog/dataPkg.sv
verilog/dstTracker.sv
verilog/operandForward.sv
verilog/flowGuard.sv
verilog/issueStage.sv
verilog/decodeHazardTop.sv
tests/decodeHazardProperties.sv
tests/decodeHazardTb.sv

//--- tests/decodeHazardProperties.sv
`timescale 1ns/1ns

module decodeHazardProperties (
	input logic clk,
	input logic rstN,
	input hazardPkg::decInfoT decIn,
	input logic stall,
	input hazardPkg::decInfoT issueRec,
	input dataPkg::operandsT issueOps
);

	// a stalled cycle must put a bubble into ID/EX.
	stallBubble: assert property (@(posedge clk) disable iff (!rstN)
		stall |=> (issueRec == '0))
		else $error("issue register not zero after a stall cycle");

	// only a jalr ever waits in decode.
	stallOnJalr: assert property (@(posedge clk) disable iff (!rstN)
		stall |-> decIn.jalr)
		else $error("stall raised for an instruction that is not a jalr");

	resetQuiet: assert property (@(posedge clk)
		!rstN |-> (issueRec == '0 && issueOps == '0 && !stall))
		else $error("outputs active while in reset");

endmodule

bind issueStage decodeHazardProperties props (
	.clk(clk),
	.rstN(rstN),
	.decIn(decIn),
	.stall(stall),
	.issueRec(issueRec),
	.issueOps(issueOps)
);

//--- tests/decodeHazardTb.sv
`timescale 1ns/1ns

module decodeHazardTb;

	// one decode cycle of stimulus and what it should produce.
	typedef struct packed {
		hazardPkg::decInfoT dec;
		logic [2:0] expFlags; // stall, jalrPredEn, branchPredEn.
		logic expIssue; // low when a bubble goes on instead.
		hazardPkg::fwdSelT src1;
		hazardPkg::fwdSelT src2;
	} rowT;

	logic clk;
	logic rstN;
	hazardPkg::decInfoT decIn;
	dataPkg::operandsT regVals;
	dataPkg::wordT memResult;
	dataPkg::wordT wbResult;
	hazardPkg::decInfoT issueRec;
	dataPkg::operandsT issueOps;
	logic stall;
	logic jalrPredEn;
	logic branchPredEn;

	rowT rows[$];
	dataPkg::operandsT rowRegs[$];
	dataPkg::wordT rowMem[$];
	dataPkg::wordT rowWb[$];
	logic [31:0] lfsrState;
	int resetCycles;
	int timeLimit;
	int checkCount;
	int errorCount;

	decodeHazardTop DUT (
		.clk(clk),
		.rstN(rstN),
		.decIn(decIn),
		.regVals(regVals),
		.memResult(memResult),
		.wbResult(wbResult),
		.issueRec(issueRec),
		.issueOps(issueOps),
		.stall(stall),
		.jalrPredEn(jalrPredEn),
		.branchPredEn(branchPredEn)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// taps 32, 22, 2, 1.
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic nextWord(output dataPkg::wordT w);
		w = '0;
		for (int b = 0; b < dataPkg::xlen; b++) begin
			lfsrState = lfsrStep(lfsrState);
			w = {w[dataPkg::xlen-2:0], lfsrState[0]};
		end
	endtask

	function automatic hazardPkg::decInfoT baseOp(input hazardPkg::regAddrT rs1,
		input hazardPkg::regAddrT rs2);
		hazardPkg::decInfoT d;
		d = '0;
		d.valid = 1'b1;
		d.rs1 = rs1;
		d.rs2 = rs2;
		return d;
	endfunction

	function automatic hazardPkg::decInfoT aluOp(input hazardPkg::regAddrT rs1,
		input hazardPkg::regAddrT rs2, input hazardPkg::regAddrT rd);
		hazardPkg::decInfoT d;
		d = baseOp(rs1, rs2);
		d.rd = rd;
		d.regWrite = 1'b1;
		return d;
	endfunction

	function automatic hazardPkg::decInfoT loadOp(input hazardPkg::regAddrT rs1,
		input hazardPkg::regAddrT rd);
		hazardPkg::decInfoT d;
		d = aluOp(rs1, 5'd0, rd);
		d.memRead = 1'b1;
		return d;
	endfunction

	function automatic hazardPkg::decInfoT jalrOp(input hazardPkg::regAddrT rs1);
		hazardPkg::decInfoT d;
		d = baseOp(rs1, 5'd0);
		d.jalr = 1'b1;
		return d;
	endfunction

	function automatic hazardPkg::decInfoT branchOp(input hazardPkg::regAddrT rs1,
		input hazardPkg::regAddrT rs2);
		hazardPkg::decInfoT d;
		d = baseOp(rs1, rs2);
		d.bType = 1'b1;
		return d;
	endfunction

	task automatic addRow(input hazardPkg::decInfoT dec, input logic [2:0] flags,
		input logic issue, input hazardPkg::fwdSelT src1, input hazardPkg::fwdSelT src2);
		rowT r;
		r.dec = dec;
		r.expFlags = flags;
		r.expIssue = issue;
		r.src1 = src1;
		r.src2 = src2;
		rows.push_back(r);
	endtask

	// an instruction in row i sits in idEx, ex, mem, wb for rows i+1 to i+4.
	task automatic buildTable();
		addRow(aluOp(5'd2, 5'd3, 5'd5), 3'b000, 1'b1, hazardPkg::fwdReg, hazardPkg::fwdReg);
		addRow(aluOp(5'd8, 5'd9, 5'd6), 3'b000, 1'b1, hazardPkg::fwdReg, hazardPkg::fwdReg);
		addRow('0, 3'b000, 1'b0, hazardPkg::fwdReg, hazardPkg::fwdReg);
		addRow(aluOp(5'd5, 5'd6, 5'd7), 3'b000, 1'b1, hazardPkg::fwdMem, hazardPkg::fwdReg);
		addRow(aluOp(5'd6, 5'd5, 5'd0), 3'b000, 1'b1, hazardPkg::fwdMem, hazardPkg::fwdWb);
		addRow(aluOp(5'd12, 5'd13, 5'd11), 3'b000, 1'b1, hazardPkg::fwdReg, hazardPkg::fwdReg);
		addRow(aluOp(5'd14, 5'd15, 5'd11), 3'b000, 1'b1, hazardPkg::fwdReg, hazardPkg::fwdReg);
		// x0 writer in mem is ignored.
		addRow(aluOp(5'd0, 5'd7, 5'd16), 3'b000, 1'b1, hazardPkg::fwdReg, hazardPkg::fwdWb);
		addRow(aluOp(5'd11, 5'd11, 5'd17), 3'b000, 1'b1, hazardPkg::fwdMem, hazardPkg::fwdMem);
		addRow(aluOp(5'd11, 5'd20, 5'd18), 3'b000, 1'b1, hazardPkg::fwdMem, hazardPkg::fwdReg);
		addRow(aluOp(5'd11, 5'd0, 5'd19), 3'b000, 1'b1, hazardPkg::fwdWb, hazardPkg::fwdReg);
		// load reaches mem under a jalr on x21.
		addRow(loadOp(5'd2, 5'd21), 3'b000, 1'b1, hazardPkg::fwdReg, hazardPkg::fwdReg);
		addRow('0, 3'b000, 1'b0, hazardPkg::fwdReg, hazardPkg::fwdReg);
		addRow('0, 3'b000, 1'b0, hazardPkg::fwdReg, hazardPkg::fwdReg);
		addRow(jalrOp(5'd21), 3'b100, 1'b0, hazardPkg::fwdReg, hazardPkg::fwdReg);
		addRow(jalrOp(5'd21), 3'b000, 1'b1, hazardPkg::fwdWb, hazardPkg::fwdReg);
		// ex non-load under a jalr on x22.
		addRow(aluOp(5'd2, 5'd3, 5'd22), 3'b000, 1'b1, hazardPkg::fwdReg, hazardPkg::fwdReg);
		addRow('0, 3'b000, 1'b0, hazardPkg::fwdReg, hazardPkg::fwdReg);
		addRow(jalrOp(5'd22), 3'b100, 1'b0, hazardPkg::fwdReg, hazardPkg::fwdReg);
		addRow(jalrOp(5'd22), 3'b000, 1'b1, hazardPkg::fwdMem, hazardPkg::fwdReg);
		addRow(aluOp(5'd8, 5'd9, 5'd23), 3'b000, 1'b1, hazardPkg::fwdReg, hazardPkg::fwdReg);
		addRow(jalrOp(5'd23), 3'b000, 1'b1, hazardPkg::fwdReg, hazardPkg::fwdReg);
		// returns through ra.
		addRow(aluOp(5'd2, 5'd3, 5'd1), 3'b000, 1'b1, hazardPkg::fwdReg, hazardPkg::fwdReg);
		addRow(jalrOp(5'd1), 3'b010, 1'b1, hazardPkg::fwdReg, hazardPkg::fwdReg);
		addRow(jalrOp(5'd1), 3'b010, 1'b1, hazardPkg::fwdReg, hazardPkg::fwdReg);
		addRow(loadOp(5'd2, 5'd1), 3'b000, 1'b1, hazardPkg::fwdReg, hazardPkg::fwdReg);
		addRow('0, 3'b000, 1'b0, hazardPkg::fwdReg, hazardPkg::fwdReg);
		addRow('0, 3'b000, 1'b0, hazardPkg::fwdReg, hazardPkg::fwdReg);
		addRow(jalrOp(5'd1), 3'b010, 1'b1, hazardPkg::fwdReg, hazardPkg::fwdReg);
		addRow(jalrOp(5'd1), 3'b000, 1'b1, hazardPkg::fwdWb, hazardPkg::fwdReg);
		// conditional branches.
		addRow(aluOp(5'd2, 5'd3, 5'd24), 3'b000, 1'b1, hazardPkg::fwdReg, hazardPkg::fwdReg);
		addRow(branchOp(5'd25, 5'd24), 3'b001, 1'b1, hazardPkg::fwdReg, hazardPkg::fwdReg);
		addRow(branchOp(5'd24, 5'd25), 3'b001, 1'b1, hazardPkg::fwdReg, hazardPkg::fwdReg);
		addRow(loadOp(5'd2, 5'd25), 3'b000, 1'b1, hazardPkg::fwdReg, hazardPkg::fwdReg);
		addRow('0, 3'b000, 1'b0, hazardPkg::fwdReg, hazardPkg::fwdReg);
		addRow('0, 3'b000, 1'b0, hazardPkg::fwdReg, hazardPkg::fwdReg);
		addRow(branchOp(5'd26, 5'd25), 3'b001, 1'b1, hazardPkg::fwdReg, hazardPkg::fwdReg);
		addRow(branchOp(5'd25, 5'd26), 3'b000, 1'b1, hazardPkg::fwdWb, hazardPkg::fwdReg);
		addRow('0, 3'b000, 1'b0, hazardPkg::fwdReg, hazardPkg::fwdReg);
	endtask

	task automatic fillWords();
		dataPkg::operandsT regs;
		dataPkg::wordT w;
		foreach (rows[i]) begin
			nextWord(regs.rs1Val);
			nextWord(regs.rs2Val);
			rowRegs.push_back(regs);
			nextWord(w);
			rowMem.push_back(w);
			nextWord(w);
			rowWb.push_back(w);
		end
	endtask

	function automatic dataPkg::wordT pickWord(input hazardPkg::fwdSelT src,
		input dataPkg::wordT regWord, input dataPkg::wordT memWord,
		input dataPkg::wordT wbWord);
		if (src == hazardPkg::fwdMem)
			return memWord;
		if (src == hazardPkg::fwdWb)
			return wbWord;
		return regWord;
	endfunction

	task automatic checkFlag(input string name, input logic actual, input logic expected);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("FAILED at %0t: %s expected %b, got %b", $time, name, expected, actual);
		end
	endtask

	task automatic checkRec(input string name, input hazardPkg::decInfoT actual,
		input hazardPkg::decInfoT expected);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	task automatic checkOps(input string name, input dataPkg::operandsT actual,
		input dataPkg::operandsT expected);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	// what the ID/EX register must hold one edge after row idx.
	task automatic checkIssue(input int idx);
		hazardPkg::decInfoT expRec;
		dataPkg::operandsT expOps;
		expRec = '0;
		expOps = '0;
		if (rows[idx].expIssue) begin
			expRec = rows[idx].dec;
			expOps.rs1Val = pickWord(rows[idx].src1, rowRegs[idx].rs1Val, rowMem[idx], rowWb[idx]);
			expOps.rs2Val = pickWord(rows[idx].src2, rowRegs[idx].rs2Val, rowMem[idx], rowWb[idx]);
		end
		checkRec("issueRec", issueRec, expRec);
		checkOps("issueOps", issueOps, expOps);
	endtask

	initial begin
		resetCycles = 16;
		checkCount = 0;
		errorCount = 0;
		lfsrState = 32'h1f82;
		rstN = 1'b0;
		buildTable();
		fillWords();
		// a live instruction sits in decode for the whole reset.
		decIn = aluOp(5'd2, 5'd3, 5'd4);
		regVals = rowRegs[0];
		memResult = '0;
		wbResult = '0;
		timeLimit = (rows.size() + resetCycles + 20) * 20;
		repeat (resetCycles - 1) @(posedge clk);
		@(negedge clk);
		checkFlag("stall", stall, 1'b0);
		checkFlag("jalrPredEn", jalrPredEn, 1'b0);
		checkFlag("branchPredEn", branchPredEn, 1'b0);
		checkRec("issueRec", issueRec, '0);
		checkOps("issueOps", issueOps, '0);
		@(posedge clk);
		rstN <= 1'b1;
		decIn <= '0;
		regVals <= '0;
		for (int i = 0; i < rows.size(); i++) begin
			@(posedge clk);
			decIn <= rows[i].dec;
			regVals <= rowRegs[i];
			memResult <= rowMem[i];
			wbResult <= rowWb[i];
			@(negedge clk);
			checkFlag("stall", stall, rows[i].expFlags[2]);
			checkFlag("jalrPredEn", jalrPredEn, rows[i].expFlags[1]);
			checkFlag("branchPredEn", branchPredEn, rows[i].expFlags[0]);
			if (i > 0)
				checkIssue(i - 1);
		end
		@(posedge clk);
		decIn <= '0;
		@(negedge clk);
		checkIssue(rows.size() - 1); // last row lands here.
		$display("checks %0d, errors %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

	initial begin
		wait (timeLimit > 0);
		#(timeLimit);
		$display("timeout: the run did not finish within %0d ns", timeLimit);
		$display("Some tests failed");
		$finish;
	end

endmodule

//--- verilog/dataPkg.sv
package dataPkg;

	localparam int xlen = 32;

	typedef logic [xlen-1:0] wordT;

	// both source operands of one instruction.
	typedef struct packed {
		wordT rs1Val;
		wordT rs2Val;
	} operandsT;

endpackage

//--- verilog/decodeHazardTop.sv
`timescale 1ns/1ns

module decodeHazardTop (
	input logic clk,
	input logic rstN,
	input hazardPkg::decInfoT decIn,
	input dataPkg::operandsT regVals,
	input dataPkg::wordT memResult,
	input dataPkg::wordT wbResult,
	output hazardPkg::decInfoT issueRec,
	output dataPkg::operandsT issueOps,
	output logic stall,
	output logic jalrPredEn,
	output logic branchPredEn
);

	hazardPkg::dstPipeT dstPipe;
	dataPkg::operandsT fwdOps;

	// destinations of everything issued and not yet written back.
	dstTracker tracker (
		.clk(clk),
		.rstN(rstN),
		.issueRec(issueRec),
		.dstPipe(dstPipe)
	);

	operandForward forward (
		.decIn(decIn),
		.dstPipe(dstPipe),
		.regVals(regVals),
		.memResult(memResult),
		.wbResult(wbResult),
		.fwdOps(fwdOps),
		.fwdSel1(),
		.fwdSel2()
	);

	// stall and predictor enables, same cycle as decIn.
	flowGuard guard (
		.decIn(decIn),
		.dstPipe(dstPipe),
		.stall(stall),
		.jalrPredEn(jalrPredEn),
		.branchPredEn(branchPredEn)
	);

	issueStage issue (
		.clk(clk),
		.rstN(rstN),
		.decIn(decIn),
		.fwdOps(fwdOps),
		.stall(stall),
		.issueRec(issueRec),
		.issueOps(issueOps)
	);

endmodule

//--- verilog/dstTracker.sv
`timescale 1ns/1ns

module dstTracker (
	input logic clk,
	input logic rstN,
	input hazardPkg::decInfoT issueRec,
	output hazardPkg::dstPipeT dstPipe
);

	hazardPkg::dstRecT idExRec;
	hazardPkg::dstRecT exRec;
	hazardPkg::dstRecT memRec;
	hazardPkg::dstRecT wbRec;

	// the ID/EX record is the issue register itself.
	// a bubble has valid low, so it never writes.
	always_comb begin
		idExRec.regWrite = issueRec.valid && issueRec.regWrite;
		idExRec.memRead = issueRec.valid && issueRec.memRead;
		idExRec.rd = issueRec.rd;
	end

	// ex, mem and wb advance every clock.
	// nothing downstream of issue ever stalls.
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			exRec <= '0;
			memRec <= '0;
			wbRec <= '0;
		end else begin
			exRec <= idExRec;
			memRec <= exRec;
			wbRec <= memRec;
		end
	end

	always_comb begin
		dstPipe.idEx = idExRec;
		dstPipe.ex = exRec;
		dstPipe.mem = memRec;
		dstPipe.wb = wbRec;
	end

endmodule

//--- verilog/flowGuard.sv
`timescale 1ns/1ns

module flowGuard (
	input hazardPkg::decInfoT decIn,
	input hazardPkg::dstPipeT dstPipe,
	output logic stall,
	output logic jalrPredEn,
	output logic branchPredEn
);

	logic isJalr;
	logic isBranch;
	logic rs1IsRa;
	logic idExLive;
	logic exLive;
	logic memLoadLive;
	logic rs1IdEx;
	logic rs1Ex;
	logic rs1ExNoLoad;
	logic rs1MemLoad;
	logic rs2IdEx;
	logic rs2Ex;
	logic rs2MemLoad;

	assign isJalr = decIn.valid && decIn.jalr;
	assign isBranch = decIn.valid && decIn.bType;
	assign rs1IsRa = decIn.rs1 == hazardPkg::raAddr;

	// x0 writers never count.
	assign idExLive = dstPipe.idEx.regWrite && (dstPipe.idEx.rd != '0);
	assign exLive = dstPipe.ex.regWrite && (dstPipe.ex.rd != '0);
	assign memLoadLive = dstPipe.mem.regWrite && dstPipe.mem.memRead &&
		(dstPipe.mem.rd != '0);

	assign rs1IdEx = idExLive && (dstPipe.idEx.rd == decIn.rs1);
	assign rs1Ex = exLive && (dstPipe.ex.rd == decIn.rs1);
	assign rs1ExNoLoad = rs1Ex && !dstPipe.ex.memRead;
	assign rs1MemLoad = memLoadLive && (dstPipe.mem.rd == decIn.rs1);

	assign rs2IdEx = idExLive && (dstPipe.idEx.rd == decIn.rs2);
	assign rs2Ex = exLive && (dstPipe.ex.rd == decIn.rs2);
	assign rs2MemLoad = memLoadLive && (dstPipe.mem.rd == decIn.rs2);

	// jalr through some other register must wait for a forwardable value.
	assign stall = isJalr && !rs1IsRa && (rs1ExNoLoad || rs1MemLoad);

	// return target still in flight so the predictor supplies it.
	assign jalrPredEn = isJalr && rs1IsRa && (rs1IdEx || rs1Ex || rs1MemLoad);

	assign branchPredEn = isBranch && (rs1IdEx || rs2IdEx ||
		rs1Ex || rs2Ex ||
		rs1MemLoad || rs2MemLoad);

endmodule

//--- verilog/hazardPkg.sv
package hazardPkg;

	// architectural register number, x0 to x31.
	typedef logic [4:0] regAddrT;

	localparam regAddrT raAddr = 5'd1; // x1 holds the return address.

	// fields of the instruction sitting in decode.
	typedef struct packed {
		logic valid;
		regAddrT rs1;
		regAddrT rs2;
		regAddrT rd;
		logic regWrite;
		logic memRead; // load.
		logic jalr;
		logic bType; // conditional branch.
	} decInfoT;

	// what an older instruction will write, and whether it is a load.
	typedef struct packed {
		logic regWrite;
		logic memRead;
		regAddrT rd;
	} dstRecT;

	// one record per stage still ahead of write-back.
	typedef struct packed {
		dstRecT idEx;
		dstRecT ex;
		dstRecT mem;
		dstRecT wb;
	} dstPipeT;

	// operand source.
	// bit 0 is the wb path, bit 1 the memory-stage path.
	typedef enum logic [1:0] {
		fwdReg = 2'b00,
		fwdWb = 2'b01,
		fwdMem = 2'b10
	} fwdSelT;

endpackage

//--- verilog/issueStage.sv
`timescale 1ns/1ns

module issueStage (
	input logic clk,
	input logic rstN,
	input hazardPkg::decInfoT decIn,
	input dataPkg::operandsT fwdOps,
	input logic stall,
	output hazardPkg::decInfoT issueRec,
	output dataPkg::operandsT issueOps
);

	logic take; // decode hands over a real instruction this cycle.

	assign take = decIn.valid && !stall;

	// ID/EX register.
	// a stalled jalr stays in decode and a zero bubble goes on instead.
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			issueRec <= '0;
			issueOps <= '0;
		end else if (take) begin
			issueRec <= decIn;
			issueOps <= fwdOps;
		end else begin
			issueRec <= '0; // bubble.
			issueOps <= '0;
		end
	end

endmodule

//--- verilog/operandForward.sv
`timescale 1ns/1ns

module operandForward (
	input hazardPkg::decInfoT decIn,
	input hazardPkg::dstPipeT dstPipe,
	input dataPkg::operandsT regVals,
	input dataPkg::wordT memResult,
	input dataPkg::wordT wbResult,
	output dataPkg::operandsT fwdOps,
	output hazardPkg::fwdSelT fwdSel1,
	output hazardPkg::fwdSelT fwdSel2
);

	logic memLive; // mem stage has a non-load writer of a real register.
	logic wbLive;
	logic rs1Mem;
	logic rs1Wb;
	logic rs2Mem;
	logic rs2Wb;

	// load data is not back yet in mem, so only ALU results qualify.
	assign memLive = dstPipe.mem.regWrite && !dstPipe.mem.memRead &&
		(dstPipe.mem.rd != '0);
	assign wbLive = dstPipe.wb.regWrite && (dstPipe.wb.rd != '0);

	assign rs1Mem = memLive && (dstPipe.mem.rd == decIn.rs1);
	assign rs1Wb = wbLive && (dstPipe.wb.rd == decIn.rs1);
	assign rs2Mem = memLive && (dstPipe.mem.rd == decIn.rs2);
	assign rs2Wb = wbLive && (dstPipe.wb.rd == decIn.rs2);

	// younger result wins.
	always_comb begin
		if (rs1Mem)
			fwdSel1 = hazardPkg::fwdMem;
		else if (rs1Wb)
			fwdSel1 = hazardPkg::fwdWb;
		else
			fwdSel1 = hazardPkg::fwdReg;

		if (rs2Mem)
			fwdSel2 = hazardPkg::fwdMem;
		else if (rs2Wb)
			fwdSel2 = hazardPkg::fwdWb;
		else
			fwdSel2 = hazardPkg::fwdReg;
	end

	always_comb begin
		case (fwdSel1)
			hazardPkg::fwdMem: fwdOps.rs1Val = memResult;
			hazardPkg::fwdWb: fwdOps.rs1Val = wbResult;
			default: fwdOps.rs1Val = regVals.rs1Val;
		endcase

		case (fwdSel2)
			hazardPkg::fwdMem: fwdOps.rs2Val = memResult;
			hazardPkg::fwdWb: fwdOps.rs2Val = wbResult;
			default: fwdOps.rs2Val = regVals.rs2Val;
		endcase
	end

endmodule
